/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // width of one gpio bank
  localparam int unsigned BANK_W = 8;
  // jtag instruction register width
  localparam int unsigned IR_W   = 4;

  // pin values of a single bank
  typedef logic [BANK_W-1:0] gpio_bank_t;
  // one jtag instruction
  typedef logic [IR_W-1:0]   jtag_ir_t;
  // device identification word
  typedef logic [31:0]       idcode_t;

  // supported instructions
  localparam jtag_ir_t IR_IDCODE      = 4'h1;
  localparam jtag_ir_t IR_GPIO_ACCESS = 4'h2;
  // all other codes decode as bypass
  localparam jtag_ir_t IR_BYPASS      = 4'hF;

  // tap controller states, ieee 1149.1 encoding
  typedef enum logic [3:0] {
    TAP_EXIT2_DR  = 4'h0,
    TAP_EXIT1_DR  = 4'h1,
    TAP_SHIFT_DR  = 4'h2,
    TAP_PAUSE_DR  = 4'h3,
    TAP_SEL_IR    = 4'h4,
    TAP_UPD_DR    = 4'h5,
    TAP_CAP_DR    = 4'h6,
    TAP_SEL_DR    = 4'h7,
    TAP_EXIT2_IR  = 4'h8,
    TAP_EXIT1_IR  = 4'h9,
    TAP_SHIFT_IR  = 4'hA,
    TAP_PAUSE_IR  = 4'hB,
    TAP_IDLE      = 4'hC,
    TAP_UPD_IR    = 4'hD,
    TAP_CAP_IR    = 4'hE,
    TAP_RESET     = 4'hF
  } tap_state_e;

endpackage

`default_nettype wire

/* hw/gpio_bank.sv */
`default_nettype none

module gpio_bank (
  input  logic                clock_i,
  input  logic                reset_i,
  input  logic                wr_i,
  input  logic                wmask_i,
  input  logic                cap_i,
  input  soc_pkg::gpio_bank_t wdata_i,
  input  soc_pkg::gpio_bank_t pin_i,
  output soc_pkg::gpio_bank_t out_o,
  output soc_pkg::gpio_bank_t in_o,
  output logic                chg_o
);

  soc_pkg::gpio_bank_t out_q;
  soc_pkg::gpio_bank_t meta_q;
  soc_pkg::gpio_bank_t sync_q;
  soc_pkg::gpio_bank_t prev_q;
  logic                chg_q;

  // output register, loads only when this bank is masked in
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      out_q <= '0;
    end else if (wr_i && wmask_i) begin
      out_q <= wdata_i;
    end
  end

  // pin synchronizer plus previous value for change detect
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
      chg_q  <= 1'b0;
    end else begin
      meta_q <= pin_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
      // sticky flag, a change wins over a capture clear
      chg_q  <= (chg_q & ~cap_i) | (sync_q != prev_q);
    end
  end

  assign out_o = out_q;
  assign in_o  = sync_q;
  assign chg_o = chg_q;

endmodule

`default_nettype wire

/* hw/gpio_collect.sv */
`default_nettype none

module gpio_collect #(
  parameter int unsigned NUM_BANKS = 4
) (
  input  logic                                     clock_i,
  input  logic                                     reset_i,
  input  soc_pkg::gpio_bank_t [NUM_BANKS-1:0]      bank_out_i,
  input  soc_pkg::gpio_bank_t [NUM_BANKS-1:0]      bank_in_i,
  input  logic [NUM_BANKS-1:0]                     bank_chg_i,
  output logic [NUM_BANKS*soc_pkg::BANK_W-1:0]     gpio_o,
  output logic [NUM_BANKS*(soc_pkg::BANK_W+1)-1:0] cap_word_o
);

  localparam int unsigned DATA_W = NUM_BANKS * soc_pkg::BANK_W;

  logic [DATA_W-1:0] out_flat;
  logic [DATA_W-1:0] in_flat;
  logic [DATA_W-1:0] gpio_q;

  // bank i lands on pins i*BANK_W upward
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      out_flat[i*soc_pkg::BANK_W +: soc_pkg::BANK_W] = bank_out_i[i];
      in_flat[i*soc_pkg::BANK_W +: soc_pkg::BANK_W]  = bank_in_i[i];
    end
  end

  // registered output pins
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      gpio_q <= '0;
    end else begin
      gpio_q <= out_flat;
    end
  end

  assign gpio_o     = gpio_q;
  // flags on top of the synchronized input data
  assign cap_word_o = {bank_chg_i, in_flat};

endmodule

`default_nettype wire

/* hw/jtag_tap.sv */
`default_nettype none

module jtag_tap #(
  parameter int unsigned      NUM_BANKS = 4,
  parameter soc_pkg::idcode_t JTAG_ID   = 32'h0000_0001
) (
  input  logic                                    clock_i,
  input  logic                                    reset_i,
  input  logic                                    jtag_tck_i,
  input  logic                                    jtag_tms_i,
  input  logic                                    jtag_tdi_i,
  input  logic                                    jtag_trst_ni,
  input  logic [NUM_BANKS*(soc_pkg::BANK_W+1)-1:0] cap_word_i,
  output logic                                    jtag_tdo_o,
  output logic                                    gpio_wr_o,
  output logic [NUM_BANKS*soc_pkg::BANK_W-1:0]     gpio_wdata_o,
  output logic [NUM_BANKS-1:0]                    gpio_wmask_o,
  output logic                                    gpio_cap_o
);

  localparam int unsigned DATA_W = NUM_BANKS * soc_pkg::BANK_W;
  localparam int unsigned DR_W   = DATA_W + NUM_BANKS;
  // capture-ir pattern, low two bits fixed at 01
  localparam soc_pkg::jtag_ir_t IR_CAPTURE = 4'b0101;

  // sync stages, bit order {trst_n, tdi, tms, tck}
  logic [3:0]          sync1_q;
  logic [3:0]          sync2_q;
  logic                tck_prev_q;
  logic                tck_s;
  logic                tms_s;
  logic                tdi_s;
  logic                trst_s;
  logic                tck_rise;
  logic                tck_fall;
  logic                tap_rst;

  soc_pkg::tap_state_e state_q;
  soc_pkg::tap_state_e state_d;

  soc_pkg::jtag_ir_t   ir_q;
  soc_pkg::jtag_ir_t   ir_shift_q;
  soc_pkg::jtag_ir_t   ir_eff;
  logic                sel_idcode;
  logic                sel_gpio;
  logic                sel_bypass;

  soc_pkg::idcode_t    idcode_dr_q;
  logic                bypass_q;
  logic [DR_W-1:0]     gpio_dr_q;
  logic                dr_cap_q;
  logic                dr_upd_q;
  logic                dr_lsb;
  logic                tdo_q;

  // two flop synchronizers, trst_n idles high
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      sync1_q    <= 4'b1000;
      sync2_q    <= 4'b1000;
      tck_prev_q <= 1'b0;
    end else begin
      sync1_q    <= {jtag_trst_ni, jtag_tdi_i, jtag_tms_i, jtag_tck_i};
      sync2_q    <= sync1_q;
      tck_prev_q <= sync2_q[0];
    end
  end

  assign tck_s    = sync2_q[0];
  assign tms_s    = sync2_q[1];
  assign tdi_s    = sync2_q[2];
  assign trst_s   = sync2_q[3];
  // edges of the oversampled tck
  assign tck_rise = tck_s & ~tck_prev_q;
  assign tck_fall = ~tck_s & tck_prev_q;
  // trst only resets the tap
  assign tap_rst  = reset_i | ~trst_s;

  // tap next state on tms
  always_comb begin
    case (state_q)
      soc_pkg::TAP_RESET:    state_d = tms_s ? soc_pkg::TAP_RESET    : soc_pkg::TAP_IDLE;
      soc_pkg::TAP_IDLE:     state_d = tms_s ? soc_pkg::TAP_SEL_DR   : soc_pkg::TAP_IDLE;
      soc_pkg::TAP_SEL_DR:   state_d = tms_s ? soc_pkg::TAP_SEL_IR   : soc_pkg::TAP_CAP_DR;
      soc_pkg::TAP_CAP_DR:   state_d = tms_s ? soc_pkg::TAP_EXIT1_DR : soc_pkg::TAP_SHIFT_DR;
      soc_pkg::TAP_SHIFT_DR: state_d = tms_s ? soc_pkg::TAP_EXIT1_DR : soc_pkg::TAP_SHIFT_DR;
      soc_pkg::TAP_EXIT1_DR: state_d = tms_s ? soc_pkg::TAP_UPD_DR   : soc_pkg::TAP_PAUSE_DR;
      soc_pkg::TAP_PAUSE_DR: state_d = tms_s ? soc_pkg::TAP_EXIT2_DR : soc_pkg::TAP_PAUSE_DR;
      soc_pkg::TAP_EXIT2_DR: state_d = tms_s ? soc_pkg::TAP_UPD_DR   : soc_pkg::TAP_SHIFT_DR;
      soc_pkg::TAP_UPD_DR:   state_d = tms_s ? soc_pkg::TAP_SEL_DR   : soc_pkg::TAP_IDLE;
      soc_pkg::TAP_SEL_IR:   state_d = tms_s ? soc_pkg::TAP_RESET    : soc_pkg::TAP_CAP_IR;
      soc_pkg::TAP_CAP_IR:   state_d = tms_s ? soc_pkg::TAP_EXIT1_IR : soc_pkg::TAP_SHIFT_IR;
      soc_pkg::TAP_SHIFT_IR: state_d = tms_s ? soc_pkg::TAP_EXIT1_IR : soc_pkg::TAP_SHIFT_IR;
      soc_pkg::TAP_EXIT1_IR: state_d = tms_s ? soc_pkg::TAP_UPD_IR   : soc_pkg::TAP_PAUSE_IR;
      soc_pkg::TAP_PAUSE_IR: state_d = tms_s ? soc_pkg::TAP_EXIT2_IR : soc_pkg::TAP_PAUSE_IR;
      soc_pkg::TAP_EXIT2_IR: state_d = tms_s ? soc_pkg::TAP_UPD_IR   : soc_pkg::TAP_SHIFT_IR;
      soc_pkg::TAP_UPD_IR:   state_d = tms_s ? soc_pkg::TAP_SEL_DR   : soc_pkg::TAP_IDLE;
      default:               state_d = soc_pkg::TAP_RESET;
    endcase
  end

  // state advances once per detected tck rise
  always_ff @(posedge clock_i) begin
    if (tap_rst) begin
      state_q <= soc_pkg::TAP_RESET;
    end else if (tck_rise) begin
      state_q <= state_d;
    end
  end

  // instruction shift register
  always_ff @(posedge clock_i) begin
    if (tck_rise) begin
      if (state_d == soc_pkg::TAP_CAP_IR) begin
        ir_shift_q <= IR_CAPTURE;
      end else if (state_q == soc_pkg::TAP_SHIFT_IR) begin
        ir_shift_q <= {tdi_s, ir_shift_q[soc_pkg::IR_W-1:1]};
      end
    end
  end

  // active instruction, idcode whenever the tap sits in reset
  always_ff @(posedge clock_i) begin
    if (tap_rst || state_q == soc_pkg::TAP_RESET) begin
      ir_q <= soc_pkg::IR_IDCODE;
    end else if (tck_rise && state_d == soc_pkg::TAP_UPD_IR) begin
      ir_q <= ir_shift_q;
    end
  end

  // unknown codes fall back to bypass
  always_comb begin
    case (ir_q)
      soc_pkg::IR_IDCODE:      ir_eff = soc_pkg::IR_IDCODE;
      soc_pkg::IR_GPIO_ACCESS: ir_eff = soc_pkg::IR_GPIO_ACCESS;
      default:                 ir_eff = soc_pkg::IR_BYPASS;
    endcase
  end

  assign sel_idcode = (ir_eff == soc_pkg::IR_IDCODE);
  assign sel_gpio   = (ir_eff == soc_pkg::IR_GPIO_ACCESS);
  assign sel_bypass = (ir_eff == soc_pkg::IR_BYPASS);

  // single cycle markers on entry to capture-dr and update-dr
  always_ff @(posedge clock_i) begin
    if (tap_rst) begin
      dr_cap_q <= 1'b0;
      dr_upd_q <= 1'b0;
    end else begin
      dr_cap_q <= tck_rise && (state_d == soc_pkg::TAP_CAP_DR);
      dr_upd_q <= tck_rise && (state_d == soc_pkg::TAP_UPD_DR);
    end
  end

  // data registers, capture in the marker cycle then shift lsb first
  always_ff @(posedge clock_i) begin
    if (dr_cap_q) begin
      if (sel_idcode) begin
        idcode_dr_q <= JTAG_ID;
      end else if (sel_gpio) begin
        gpio_dr_q <= cap_word_i;
      end else if (sel_bypass) begin
        bypass_q <= 1'b0;
      end
    end else if (tck_rise && state_q == soc_pkg::TAP_SHIFT_DR) begin
      if (sel_idcode) begin
        idcode_dr_q <= {tdi_s, idcode_dr_q[31:1]};
      end else if (sel_gpio) begin
        gpio_dr_q <= {tdi_s, gpio_dr_q[DR_W-1:1]};
      end else if (sel_bypass) begin
        bypass_q <= tdi_s;
      end
    end
  end

  // serial out of the selected data register
  always_comb begin
    if (sel_idcode) begin
      dr_lsb = idcode_dr_q[0];
    end else if (sel_gpio) begin
      dr_lsb = gpio_dr_q[0];
    end else begin
      dr_lsb = bypass_q;
    end
  end

  // tdo moves on the falling tck edge
  always_ff @(posedge clock_i) begin
    if (tap_rst) begin
      tdo_q <= 1'b0;
    end else if (tck_fall) begin
      if (state_q == soc_pkg::TAP_SHIFT_IR) begin
        tdo_q <= ir_shift_q[0];
      end else if (state_q == soc_pkg::TAP_SHIFT_DR) begin
        tdo_q <= dr_lsb;
      end else begin
        tdo_q <= 1'b0;
      end
    end
  end

  assign jtag_tdo_o   = tdo_q;
  // strobes only with gpio_access selected
  assign gpio_wr_o    = dr_upd_q & sel_gpio;
  assign gpio_cap_o   = dr_cap_q & sel_gpio;
  // mask bits sit above the data bits
  assign gpio_wdata_o = gpio_dr_q[DATA_W-1:0];
  assign gpio_wmask_o = gpio_dr_q[DR_W-1:DATA_W];

endmodule

`default_nettype wire

/* hw/soc_gpio_top.sv */
`default_nettype none

module soc_gpio_top #(
  parameter int unsigned NUM_BANKS = 4
) (
  input  logic                                 clock_i,
  input  logic                                 reset_i,
  input  logic                                 jtag_tck_i,
  input  logic                                 jtag_tms_i,
  input  logic                                 jtag_tdi_i,
  input  logic                                 jtag_trst_ni,
  output logic                                 jtag_tdo_o,
  input  logic [NUM_BANKS*soc_pkg::BANK_W-1:0] gpio_i,
  output logic [NUM_BANKS*soc_pkg::BANK_W-1:0] gpio_o
);

  localparam int unsigned DATA_W = NUM_BANKS * soc_pkg::BANK_W;
  localparam int unsigned DR_W   = DATA_W + NUM_BANKS;

  // idcode fields
  localparam soc_pkg::idcode_t JTAG_ID = {
    4'h1,     // version
    16'h6A10, // part number
    11'h2C5,  // manufacturer
    1'b1      // always one
  };

  logic                                gpio_wr;
  logic                                gpio_cap;
  logic [DATA_W-1:0]                   gpio_wdata;
  logic [NUM_BANKS-1:0]                gpio_wmask;
  soc_pkg::gpio_bank_t [NUM_BANKS-1:0] bank_out;
  soc_pkg::gpio_bank_t [NUM_BANKS-1:0] bank_in;
  logic [NUM_BANKS-1:0]                bank_chg;
  logic [DR_W-1:0]                     cap_word;

  jtag_tap #(
    .NUM_BANKS (NUM_BANKS),
    .JTAG_ID   (JTAG_ID)
  ) u_jtag_tap (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .jtag_tck_i   (jtag_tck_i),
    .jtag_tms_i   (jtag_tms_i),
    .jtag_tdi_i   (jtag_tdi_i),
    .jtag_trst_ni (jtag_trst_ni),
    .cap_word_i   (cap_word),
    .jtag_tdo_o   (jtag_tdo_o),
    .gpio_wr_o    (gpio_wr),
    .gpio_wdata_o (gpio_wdata),
    .gpio_wmask_o (gpio_wmask),
    .gpio_cap_o   (gpio_cap)
  );

  // one bank per byte of pins, each with its own mask bit
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    gpio_bank u_gpio_bank (
      .clock_i (clock_i),
      .reset_i (reset_i),
      .wr_i    (gpio_wr),
      .wmask_i (gpio_wmask[i]),
      .cap_i   (gpio_cap),
      .wdata_i (gpio_wdata[i*soc_pkg::BANK_W +: soc_pkg::BANK_W]),
      .pin_i   (gpio_i[i*soc_pkg::BANK_W +: soc_pkg::BANK_W]),
      .out_o   (bank_out[i]),
      .in_o    (bank_in[i]),
      .chg_o   (bank_chg[i])
    );
  end

  gpio_collect #(
    .NUM_BANKS (NUM_BANKS)
  ) u_gpio_collect (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .bank_out_i (bank_out),
    .bank_in_i  (bank_in),
    .bank_chg_i (bank_chg),
    .gpio_o     (gpio_o),
    .cap_word_o (cap_word)
  );

endmodule

`default_nettype wire

/* tb/jtag_host.svh */
`ifndef JTAG_HOST_SVH
`define JTAG_HOST_SVH

// system clocks per tck level, the tap needs at least 6
localparam int TCK_HALF = 8;

// one tck period
task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
  @(negedge clock);
  jtag_tms = tms;
  jtag_tdi = tdi;
  // tdo moved on the last falling tck edge and is stable here
  tdo      = jtag_tdo;
  // tms and tdi settle ahead of tck
  repeat (2) @(negedge clock);
  jtag_tck = 1'b1;
  repeat (TCK_HALF) @(negedge clock);
  jtag_tck = 1'b0;
  repeat (TCK_HALF) @(negedge clock);
endtask

// from test-logic-reset or idle into run-test/idle
task automatic go_idle();
  logic tdo;
  tck_cycle(1'b0, 1'b0, tdo);
endtask

// five tms high cycles force test-logic-reset
task automatic tms_reset();
  logic tdo;
  for (int i = 0; i < 5; i++) begin
    tck_cycle(1'b1, 1'b0, tdo);
  end
  go_idle();
endtask

// async tap reset pin, long enough for the synchronizer
task automatic pulse_trst();
  @(negedge clock);
  jtag_trst_n = 1'b0;
  repeat (6) @(negedge clock);
  jtag_trst_n = 1'b1;
  repeat (4) @(negedge clock);
endtask

// idle to idle, lsb first
task automatic ir_scan(input soc_pkg::jtag_ir_t ir);
  logic tdo;
  tck_cycle(1'b1, 1'b0, tdo);
  tck_cycle(1'b1, 1'b0, tdo);
  // capture-ir then shift-ir
  tck_cycle(1'b0, 1'b0, tdo);
  tck_cycle(1'b0, 1'b0, tdo);
  for (int i = 0; i < soc_pkg::IR_W; i++) begin
    tck_cycle(i == soc_pkg::IR_W - 1, ir[i], tdo);
  end
  // update-ir and back to idle
  tck_cycle(1'b1, 1'b0, tdo);
  tck_cycle(1'b0, 1'b0, tdo);
endtask

// idle to idle, len bits lsb first, ends through update-dr
task automatic dr_scan(input int len, input logic [63:0] din, output logic [63:0] dout);
  logic tdo;
  dout = '0;
  // select-dr, capture-dr, shift-dr
  tck_cycle(1'b1, 1'b0, tdo);
  tck_cycle(1'b0, 1'b0, tdo);
  tck_cycle(1'b0, 1'b0, tdo);
  for (int i = 0; i < len; i++) begin
    tck_cycle(i == len - 1, din[i], tdo);
    dout[i] = tdo;
  end
  tck_cycle(1'b1, 1'b0, tdo);
  tck_cycle(1'b0, 1'b0, tdo);
endtask

`endif

/* tb/tb_soc_gpio_top.sv */
`default_nettype none

module tb_soc_gpio_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BANKS = 4;
  localparam int DATA_W    = NUM_BANKS * soc_pkg::BANK_W;
  localparam int DR_W      = DATA_W + NUM_BANKS;
  // device id word with the mandatory lsb set
  localparam soc_pkg::idcode_t EXP_ID = 32'h16A1_058B;
  localparam int GPIO_TIMEOUT = 50;

  logic              clock;
  logic              reset;
  logic              jtag_tck;
  logic              jtag_tms;
  logic              jtag_tdi;
  logic              jtag_trst_n;
  logic              jtag_tdo;
  logic [DATA_W-1:0] gpio_in;
  logic [DATA_W-1:0] gpio_out;

  // reference model state
  soc_pkg::gpio_bank_t  exp_out [NUM_BANKS];
  logic [DATA_W-1:0]    last_pins;
  logic [NUM_BANKS-1:0] exp_chg;
  int                   seed;

  soc_gpio_top #(
    .NUM_BANKS (NUM_BANKS)
  ) u_soc_gpio_top (
    .clock_i      (clock),
    .reset_i      (reset),
    .jtag_tck_i   (jtag_tck),
    .jtag_tms_i   (jtag_tms),
    .jtag_tdi_i   (jtag_tdi),
    .jtag_trst_ni (jtag_trst_n),
    .jtag_tdo_o   (jtag_tdo),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out)
  );

  `include "jtag_host.svh"

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // expected output pins from the per-bank model
  function automatic logic [DATA_W-1:0] expected_gpio();
    logic [DATA_W-1:0] w;
    for (int b = 0; b < NUM_BANKS; b++) begin
      w[b*soc_pkg::BANK_W +: soc_pkg::BANK_W] = exp_out[b];
    end
    return w;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0d ns %s: got %0h expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // gpio_o settles a few cycles after update-dr
  task automatic wait_gpio_match();
    int cycles;
    cycles = 0;
    while (gpio_out !== expected_gpio() && cycles < GPIO_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    check_value(64'(gpio_out), 64'(expected_gpio()), "gpio_o after update-dr");
  endtask

  task automatic check_idcode(input string what);
    logic [63:0] dout;
    dr_scan(32, 64'(rand32()), dout);
    check_value(dout, 64'(EXP_ID), what);
  endtask

  // the one-bit register returns the pattern one shift late
  task automatic check_bypass(input soc_pkg::jtag_ir_t code);
    logic [63:0] din;
    logic [63:0] dout;
    din = {rand32(), rand32()};
    ir_scan(code);
    dr_scan(24, din, dout);
    check_value(dout, {40'b0, din[22:0], 1'b0}, "bypass shift");
  endtask

  // full gpio_access scan with gpio_access already selected
  task automatic gpio_scan(input logic [NUM_BANKS-1:0] mask, input logic [DATA_W-1:0] data);
    logic [63:0]     dout;
    logic [DR_W-1:0] exp_cap;
    exp_cap = {exp_chg, last_pins};
    dr_scan(DR_W, 64'({mask, data}), dout);
    check_value(dout, 64'(exp_cap), "gpio capture word");
    // capture clears the sticky flags
    exp_chg = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (mask[b]) begin
        exp_out[b] = data[b*soc_pkg::BANK_W +: soc_pkg::BANK_W];
      end
    end
    wait_gpio_match();
  endtask

  // new random bytes on a random subset of banks
  task automatic drive_pins();
    logic [DATA_W-1:0] pins;
    logic [31:0]       sel;
    logic [31:0]       val;
    pins = last_pins;
    sel  = rand32();
    for (int b = 0; b < NUM_BANKS; b++) begin
      val = rand32();
      if (sel[b]) begin
        pins[b*soc_pkg::BANK_W +: soc_pkg::BANK_W] = val[7:0];
      end
      // a rewrite of the same byte is no change
      if (pins[b*soc_pkg::BANK_W +: soc_pkg::BANK_W] !=
          last_pins[b*soc_pkg::BANK_W +: soc_pkg::BANK_W]) begin
        exp_chg[b] = 1'b1;
      end
    end
    @(negedge clock);
    gpio_in   = pins;
    last_pins = pins;
    // well past synchronizer and flag delay
    repeat (10) @(negedge clock);
  endtask

  initial begin
    seed        = 10811;
    reset       = 1'b1;
    jtag_tck    = 1'b0;
    jtag_tms    = 1'b1;
    jtag_tdi    = 1'b0;
    jtag_trst_n = 1'b1;
    gpio_in     = '0;
    last_pins   = '0;
    exp_chg     = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      exp_out[b] = '0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // idcode is the reset instruction
    go_idle();
    check_idcode("idcode after reset");

    check_bypass(soc_pkg::IR_BYPASS);
    check_bypass(4'h7);

    ir_scan(soc_pkg::IR_GPIO_ACCESS);
    for (int n = 0; n < 8; n++) begin
      gpio_scan(NUM_BANKS'(rand32()), DATA_W'(rand32()));
    end

    // pin changes then a quiet second capture
    for (int n = 0; n < 6; n++) begin
      drive_pins();
      gpio_scan('0, DATA_W'(rand32()));
      gpio_scan('0, DATA_W'(rand32()));
    end

    // trst back to idcode with outputs kept
    pulse_trst();
    go_idle();
    check_idcode("idcode after trst");
    check_value(64'(gpio_out), 64'(expected_gpio()), "gpio_o through trst");

    ir_scan(soc_pkg::IR_GPIO_ACCESS);
    tms_reset();
    check_idcode("idcode after tms reset");
    check_value(64'(gpio_out), 64'(expected_gpio()), "gpio_o through tms reset");

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+tb
hw/soc_pkg.sv
hw/gpio_bank.sv
hw/gpio_collect.sv
hw/jtag_tap.sv
hw/soc_gpio_top.sv
tb/tb_soc_gpio_top.sv

/* Makefile */
TOP := tb_soc_gpio_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

lint:
	verilator --lint-only -Wall \
		hw/soc_pkg.sv hw/gpio_bank.sv hw/gpio_collect.sv \
		hw/jtag_tap.sv hw/soc_gpio_top.sv \
		--top-module soc_gpio_top

clean:
	rm -rf obj_dir
